//--- rvCore_input.txt
# group instr rdata pc dataAddr dataWdata memRead memWrite dontCare, all hex but group
# dontCare 1 masks dataAddr and dataWdata; text after the ninth column is a note
1 00500093 00000000 00000000 00000000 00000000 0 0 1 addi x1,x0,5
1 12345137 00000000 00000004 00000000 00000000 0 0 1 lui x2,0x12345
1 002081B3 00000000 00000008 00000000 00000000 0 0 1 add x3,x1,x2
1 40110233 00000000 0000000C 00000000 00000000 0 0 1 sub x4,x2,x1
1 FF000293 00000000 00000010 00000000 00000000 0 0 1 addi x5,x0,-16
1 4012D333 00000000 00000014 00000000 00000000 0 0 1 sra x6,x5,x1
1 0050B3B3 00000000 00000018 00000000 00000000 0 0 1 sltu x7,x1,x5
2 10000413 00000000 0000001C 00000000 00000000 0 0 1 addi x8,x0,0x100
2 00342023 00000000 00000020 00000100 12345005 0 1 0 sw x3,0(x8)
2 00442223 00000000 00000024 00000104 12344FFB 0 1 0 sw x4,4(x8)
2 00641423 00000000 00000028 00000108 FFFFFFFF 0 1 0 sh x6,8(x8)
2 007404A3 00000000 0000002C 00000109 00000001 0 1 0 sb x7,9(x8)
2 00700013 00000000 00000030 00000000 00000000 0 0 1 addi x0,x0,7
2 FE042E23 00000000 00000034 000000FC 00000000 0 1 0 sw x0,-4(x8)
3 00340483 80FF7F01 00000038 00000103 12345005 1 0 0 lb x9,3(x8)
3 00344503 80FF7F01 0000003C 00000103 12345005 1 0 0 lbu x10,3(x8)
3 00241583 80FF7F01 00000040 00000102 12345000 1 0 0 lh x11,2(x8)
3 00045603 1234F00D 00000044 00000100 00000000 1 0 0 lhu x12,0(x8)
3 00442683 DEADBEEF 00000048 00000104 12344FFB 1 0 0 lw x13,4(x8)
3 00942023 00000000 0000004C 00000100 FFFFFF80 0 1 0 sw x9,0(x8)
3 00A42223 00000000 00000050 00000104 00000080 0 1 0 sw x10,4(x8)
3 00B42423 00000000 00000054 00000108 FFFF80FF 0 1 0 sw x11,8(x8)
3 00C42623 00000000 00000058 0000010C 0000F00D 0 1 0 sw x12,12(x8)
3 00D42823 00000000 0000005C 00000110 DEADBEEF 0 1 0 sw x13,16(x8)
4 00708463 00000000 00000060 00000000 00000000 0 0 1 beq x1,x7,+8 not taken
4 00709463 00000000 00000064 00000000 00000000 0 0 1 bne x1,x7,+8 taken
4 0012C663 00000000 0000006C 00000000 00000000 0 0 1 blt x5,x1,+12 taken
4 0050F463 00000000 00000078 00000000 00000000 0 0 1 bgeu x1,x5,+8 not taken
4 0100076F 00000000 0000007C 00000000 00000000 0 0 1 jal x14,+16
4 09C087E7 00000000 0000008C 00000000 00000000 0 0 1 jalr x15,0x9c(x1)
4 00E42A23 00000000 000000A0 00000114 00000080 0 1 0 sw x14,20(x8)
4 00F42C23 00000000 000000A4 00000118 00000090 0 1 0 sw x15,24(x8)
5 06300893 00000000 000000A8 00000000 00000000 0 0 1 addi x17,x0,99
5 1004282F CAFEF00D 000000AC 00000100 00000000 1 0 0 lr.w x16,(x8)
5 190428AF 00000000 000000B0 00000100 CAFEF00D 0 1 0 sc.w x17,x16,(x8)
5 01142E23 00000000 000000B4 0000011C 00000000 0 1 0 sw x17,28(x8)
5 03042023 00000000 000000B8 00000120 CAFEF00D 0 1 0 sw x16,32(x8)

//--- compile.f
+incdir+.
rvPkg.sv
Control.sv
aluControl.sv
immGen.sv
regFile.sv
alu.sv
loadUnit.sv
rvCore.sv
tbRvCore.sv

//--- Makefile
TOP       ?= tbRvCore
VERILATOR ?= verilator
LOG       ?= run.log
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- tbRvCore.sv
`include "rv_defines.svh"

module tbRvCore import rvPkg::*; ();

  localparam string VECTOR_FILE = "rvCore_input.txt";
  localparam int    CLK_PERIOD  = 20;
  localparam logic [`XLEN-1:0] NOP = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM}; // ADDI x0

  logic             clk;
  logic             rstN;
  logic [`XLEN-1:0] instr;
  logic [`XLEN-1:0] dataRdata;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] dataAddr;
  logic [`XLEN-1:0] dataWdata;
  logic             memRead;
  logic             memWrite;

  // One entry per cycle of the trace
  int               vGroup [$];
  logic [`XLEN-1:0] vInstr [$];
  logic [`XLEN-1:0] vRdata [$];
  logic [`XLEN-1:0] vPc [$];
  logic [`XLEN-1:0] vAddr [$];
  logic [`XLEN-1:0] vWdata [$];
  logic             vRead [$];
  logic             vWrite [$];
  logic             vMask [$];

  int vecCount    = 0;
  bit loaded      = 1'b0;
  int groupErrors = 0;
  int groupCycles = 0;
  int totalErrors = 0;
  int passGroups  = 0;
  int failGroups  = 0;

  rvCore u_dut (
    .clk(clk), .rstN(rstN), .instr(instr), .dataRdata(dataRdata),
    .pc(pc), .dataAddr(dataAddr), .dataWdata(dataWdata),
    .memRead(memRead), .memWrite(memWrite)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic string groupName(input int id);
    case (id)
      1:       return "alu ops";
      2:       return "stores";
      3:       return "loads";
      4:       return "branches and jumps";
      5:       return "lr/sc";
      default: return "unnamed";
    endcase
  endfunction

  task automatic loadVectors(output bit ok);
    int               fd;
    int               n;
    int               grp;
    string            line;
    logic [`XLEN-1:0] wIns;
    logic [`XLEN-1:0] wRd;
    logic [`XLEN-1:0] wPc;
    logic [`XLEN-1:0] wAddr;
    logic [`XLEN-1:0] wData;
    logic             bRead;
    logic             bWrite;
    logic             bMask;
    fd = $fopen(VECTOR_FILE, "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) != "#") begin // Skip column notes
          n = $sscanf(line, "%d %h %h %h %h %h %h %h %h", grp, wIns, wRd, wPc,
                      wAddr, wData, bRead, bWrite, bMask);
          if (n == 9) begin
            vGroup.push_back(grp);
            vInstr.push_back(wIns);
            vRdata.push_back(wRd);
            vPc.push_back(wPc);
            vAddr.push_back(wAddr);
            vWdata.push_back(wData);
            vRead.push_back(bRead);
            vWrite.push_back(bWrite);
            vMask.push_back(bMask);
          end
        end
      end
      $fclose(fd);
      vecCount = vGroup.size();
    end
  endtask

  task automatic checkWord(input string name, input logic [`XLEN-1:0] expected,
                           input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
      groupErrors++;
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, expected, actual);
      groupErrors++;
    end
  endtask

  task automatic closeGroup(input int id);
    if (groupErrors == 0) begin
      $display("test %s: PASS, %0d cycles", groupName(id), groupCycles);
      passGroups++;
    end else begin
      $display("test %s: FAIL, %0d errors in %0d cycles", groupName(id), groupErrors,
               groupCycles);
      failGroups++;
    end
    totalErrors += groupErrors;
    groupErrors = 0;
    groupCycles = 0;
  endtask

  // Watchdog sized from the trace length plus reset slack
  initial begin
    wait (loaded);
    #((vecCount + 10) * CLK_PERIOD);
    $display("watchdog expired at %0t before the trace finished", $time);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    bit ok;
    int curGroup;
    clk       = 1'b0;
    rstN      = 1'b0;
    instr     = NOP; // Keeps both strobes low in reset
    dataRdata = '0;
    loadVectors(ok);
    if (!ok || vecCount == 0) begin
      $display("could not open %s or it holds no vectors", VECTOR_FILE);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (2) @(posedge clk);
      rstN <= 1'b1;
      curGroup = vGroup[0];
      for (int i = 0; i < vecCount; i++) begin
        if (vGroup[i] != curGroup) begin
          closeGroup(curGroup);
          curGroup = vGroup[i];
        end
        instr     <= vInstr[i];
        dataRdata <= vRdata[i];
        @(negedge clk); // Outputs settled mid-cycle
        groupCycles++;
        checkWord("pc", vPc[i], pc);
        checkBit("memRead", vRead[i], memRead);
        checkBit("memWrite", vWrite[i], memWrite);
        if (!vMask[i]) begin
          checkWord("dataAddr", vAddr[i], dataAddr);
          checkWord("dataWdata", vWdata[i], dataWdata);
        end
        @(posedge clk);
      end
      closeGroup(curGroup);
      $display("groups passed %0d, groups failed %0d, failed checks %0d", passGroups,
               failGroups, totalErrors);
      if (failGroups == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- rvCore.sv
`include "rv_defines.svh"

module rvCore import rvPkg::*; (
  input  logic             clk,
  input  logic             rstN,
  input  logic [`XLEN-1:0] instr,
  input  logic [`XLEN-1:0] dataRdata,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] dataAddr,
  output logic [`XLEN-1:0] dataWdata,
  output logic             memRead,
  output logic             memWrite
);

  logic             branch;
  logic             jump;
  logic             jumpRegister;
  logic             aluSrc;
  logic             pcToAlu;
  logic             regWrite;
  logic             memToReg;
  logic             scStore;
  logic             byteLoad;
  logic             halfLoad;
  logic             unsignedLoad;
  logic             taken;
  aluClassT         aluClass;
  aluFnT            aluFn;
  immFmtT           immFmt;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] rs1Data;
  logic [`XLEN-1:0] rs2Data;
  logic [`XLEN-1:0] aluA;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] loadData;
  logic [`XLEN-1:0] rdData;
  logic [`XLEN-1:0] pcPlus4;
  logic [`XLEN-1:0] pcPlusImm;
  logic [`XLEN-1:0] jalrTarget;
  logic [`XLEN-1:0] nextPc;

  Control uControl (
    .instr(instr[6:0]), .func3(instr[14:12]), .func7(instr[31:25]),
    .branch(branch), .jump(jump), .jumpRegister(jumpRegister),
    .aluClass(aluClass), .memWrite(memWrite), .aluSrc(aluSrc),
    .pcToAlu(pcToAlu), .regWrite(regWrite), .memRead(memRead),
    .memToReg(memToReg), .scStore(scStore), .byteLoad(byteLoad),
    .halfLoad(halfLoad), .unsignedLoad(unsignedLoad), .immFmt(immFmt)
  );

  aluControl uAluControl (
    .aluClass(aluClass), .func3(instr[14:12]), .func7(instr[31:25]), .aluFn(aluFn)
  );

  immGen uImmGen (.instr(instr), .immFmt(immFmt), .imm(imm));

  regFile uRegFile (
    .clk(clk), .rstN(rstN),
    .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
    .rdData(rdData), .regWrite(regWrite),
    .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  assign aluA = pcToAlu ? pc : rs1Data; // AUIPC and jumps use pc
  assign aluB = aluSrc ? imm : rs2Data;

  alu uAlu (.a(aluA), .b(aluB), .aluFn(aluFn), .result(aluResult), .taken(taken));

  loadUnit uLoadUnit (
    .rdata(dataRdata), .addrLow(aluResult[1:0]), .byteLoad(byteLoad),
    .halfLoad(halfLoad), .unsignedLoad(unsignedLoad), .loadData(loadData)
  );

  assign dataAddr  = aluResult;
  assign dataWdata = rs2Data;

  // Write-back select
  always_comb begin
    if (jump) rdData = pcPlus4; // Link
    else if (memToReg) rdData = loadData;
    else if (scStore) rdData = '0; // SC.W success
    else rdData = aluResult;
  end

  assign pcPlus4    = pc + `XLEN'(4);
  assign pcPlusImm  = pc + imm;
  assign jalrTarget = rs1Data + imm;

  always_comb begin
    if (jumpRegister) nextPc = {jalrTarget[`XLEN-1:1], 1'b0};
    else if (jump || (branch && taken)) nextPc = pcPlusImm;
    else nextPc = pcPlus4;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) pc <= `RESET_PC;
    else pc <= nextPc;
  end

  // Data memory returns a known word in every read cycle
  assert property (@(posedge clk) disable iff (!rstN) memRead |-> !$isunknown(dataRdata))
    else $error("rvCore: unknown read data at pc %h", pc);

  assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else $error("rvCore: misaligned pc %h", pc);

endmodule

//--- loadUnit.sv
`include "rv_defines.svh"

module loadUnit (
  input  logic [`XLEN-1:0] rdata,
  input  logic [1:0]       addrLow,
  input  logic             byteLoad,
  input  logic             halfLoad,
  input  logic             unsignedLoad,
  output logic [`XLEN-1:0] loadData
);

  logic [7:0]  byteSel;
  logic [15:0] halfSel;
  logic        fill;

  assign byteSel = rdata[8*addrLow +: 8]; // Little-endian lane
  assign halfSel = addrLow[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    if (byteLoad) begin
      fill     = !unsignedLoad && byteSel[7];
      loadData = {{(`XLEN-8){fill}}, byteSel};
    end else if (halfLoad) begin
      fill     = !unsignedLoad && halfSel[15];
      loadData = {{(`XLEN-16){fill}}, halfSel};
    end else begin
      fill     = 1'b0;
      loadData = rdata; // LW and LR.W
    end
  end

endmodule

//--- alu.sv
`include "rv_defines.svh"

module alu import rvPkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  aluFnT            aluFn,
  output logic [`XLEN-1:0] result,
  output logic             taken
);

  logic [4:0] shamt;
  logic       ltSigned;
  logic       ltUnsigned;
  logic       equal;

  assign shamt      = b[4:0];
  assign ltSigned   = $signed(a) < $signed(b);
  assign ltUnsigned = a < b;
  assign equal      = (a == b);

  always_comb begin
    taken  = 1'b0;
    result = '0;
    case (aluFn)
      FN_ADD:   result = a + b;
      FN_SUB:   result = a - b;
      FN_SLL:   result = a << shamt;
      FN_SLT:   result = `XLEN'(ltSigned);
      FN_SLTU:  result = `XLEN'(ltUnsigned);
      FN_XOR:   result = a ^ b;
      FN_SRL:   result = a >> shamt;
      FN_SRA:   result = $signed(a) >>> shamt; // Sign fill
      FN_OR:    result = a | b;
      FN_AND:   result = a & b;
      FN_EQ:    taken = equal;
      FN_NE:    taken = !equal;
      FN_LT:    taken = ltSigned;
      FN_GE:    taken = !ltSigned;
      FN_LTU:   taken = ltUnsigned;
      FN_GEU:   taken = !ltUnsigned;
      FN_PASSB: result = b; // LUI
      default:  result = a + b;
    endcase
    // Branch compares also report through result
    if (aluFn inside {FN_EQ, FN_NE, FN_LT, FN_GE, FN_LTU, FN_GEU}) begin
      result = `XLEN'(taken);
    end
  end

endmodule

//--- regFile.sv
`include "rv_defines.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`REG_ADDR_W-1:0] rs1Addr,
  input  logic [`REG_ADDR_W-1:0] rs2Addr,
  input  logic [`REG_ADDR_W-1:0] rdAddr,
  input  logic [`XLEN-1:0]       rdData,
  input  logic                   regWrite,
  output logic [`XLEN-1:0]       rs1Data,
  output logic [`XLEN-1:0]       rs2Data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && rdAddr != '0) begin // x0 never written
      regs[rdAddr] <= rdData;
    end
  end

  assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
  assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

  // Write-back mux must settle to a known value before every write
  assert property (@(posedge clk) disable iff (!rstN) regWrite |-> !$isunknown(rdData))
    else $error("regFile: unknown write data for x%0d", rdAddr);

endmodule

//--- immGen.sv
`include "rv_defines.svh"

module immGen import rvPkg::*; (
  input  logic [`XLEN-1:0] instr,
  input  immFmtT           immFmt,
  output logic [`XLEN-1:0] imm
);

  logic sign;

  assign sign = instr[31];

  always_comb begin
    case (immFmt)
      IMM_I: imm = {{(`XLEN-12){sign}}, instr[31:20]};
      IMM_S: imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
      IMM_B: imm = {{(`XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
      IMM_U: imm = {{(`XLEN-31){sign}}, instr[30:12], 12'b0}; // Upper twenty bits
      IMM_J: imm = {{(`XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};
      default: imm = '0; // R-type and AMO
    endcase
  end

endmodule

//--- aluControl.sv
module aluControl import rvPkg::*; (
  input  aluClassT   aluClass,
  input  logic [2:0] func3,
  input  logic [6:0] func7,
  output aluFnT      aluFn
);

  logic altFn;

  assign altFn = func7[5]; // SUB and SRA select

  always_comb begin
    aluFn = FN_ADD;
    case (aluClass)
      CLS_MEM, CLS_AMO, CLS_JUMP: aluFn = FN_ADD; // Address, AUIPC, link
      CLS_PASS:                   aluFn = FN_PASSB; // LUI
      CLS_BRANCH: begin
        case (func3)
          3'b000:  aluFn = FN_EQ;
          3'b001:  aluFn = FN_NE;
          3'b100:  aluFn = FN_LT;
          3'b101:  aluFn = FN_GE;
          3'b110:  aluFn = FN_LTU;
          3'b111:  aluFn = FN_GEU;
          default: aluFn = FN_EQ;
        endcase
      end
      CLS_OP, CLS_OP_IMM: begin
        case (func3)
          // Immediate form has no SUB, bit 30 is part of the immediate
          3'b000:  aluFn = (altFn && aluClass == CLS_OP) ? FN_SUB : FN_ADD;
          3'b001:  aluFn = FN_SLL;
          3'b010:  aluFn = FN_SLT;
          3'b011:  aluFn = FN_SLTU;
          3'b100:  aluFn = FN_XOR;
          3'b101:  aluFn = altFn ? FN_SRA : FN_SRL;
          3'b110:  aluFn = FN_OR;
          default: aluFn = FN_AND;
        endcase
      end
      default: aluFn = FN_ADD;
    endcase
  end

endmodule

//--- Control.sv
`include "rv_defines.svh"

module Control import rvPkg::*; (
  input  logic [6:0] instr,
  input  logic [2:0] func3,
  input  logic [6:0] func7,
  output logic       branch,
  output logic       jump,
  output logic       jumpRegister,
  output aluClassT   aluClass,
  output logic       memWrite,
  output logic       aluSrc,
  output logic       pcToAlu,
  output logic       regWrite,
  output logic       memRead,
  output logic       memToReg,
  output logic       scStore,
  output logic       byteLoad,
  output logic       halfLoad,
  output logic       unsignedLoad,
  output immFmtT     immFmt
);

  opcodeT opcode;
  logic   isLoad;
  logic   isLr;
  logic   isSc;

  assign opcode = opcodeT'(instr);
  assign isLoad = (opcode == OPC_LOAD);
  assign isLr   = (opcode == OPC_AMO) && (func7[6:2] == 5'b00010); // LR.W
  assign isSc   = (opcode == OPC_AMO) && (func7[6:2] == 5'b00011); // SC.W

  assign branch       = (opcode == OPC_BRANCH);
  assign jump         = (opcode == OPC_JAL) || (opcode == OPC_JALR);
  assign jumpRegister = (opcode == OPC_JALR);

  assign memRead  = isLoad || isLr;
  assign memToReg = isLoad || isLr;
  assign memWrite = (opcode == OPC_STORE) || isSc;
  assign scStore  = isSc; // rd gets zero, store always succeeds

  // AMO takes the zero immediate so the address is rs1 alone
  assign aluSrc = (opcode == OPC_OP_IMM) || isLoad || (opcode == OPC_STORE) ||
                  (opcode == OPC_LUI) || (opcode == OPC_AUIPC) || (opcode == OPC_AMO);

  assign regWrite = (opcode == OPC_OP_IMM) || isLoad || (opcode == OPC_OP) || jump ||
                    (opcode == OPC_LUI) || (opcode == OPC_AUIPC) || isLr || isSc;

  assign pcToAlu = (opcode == OPC_AUIPC) || jump;

  // Width flags only for real loads, LR.W keeps the full word
  assign byteLoad     = isLoad && (func3 == `LOAD_BYTE || func3 == `LOAD_BYTE_U);
  assign halfLoad     = isLoad && (func3 == `LOAD_HALF || func3 == `LOAD_HALF_U);
  assign unsignedLoad = isLoad && (func3 == `LOAD_BYTE_U || func3 == `LOAD_HALF_U);

  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_STORE: aluClass = CLS_MEM;
      OPC_BRANCH:          aluClass = CLS_BRANCH;
      OPC_OP:              aluClass = CLS_OP;
      OPC_JAL, OPC_JALR,
      OPC_AUIPC:           aluClass = CLS_JUMP;
      OPC_LUI:             aluClass = CLS_PASS;
      OPC_AMO:             aluClass = CLS_AMO;
      OPC_OP_IMM:          aluClass = CLS_OP_IMM;
      default:             aluClass = CLS_NONE;
    endcase
  end

  always_comb begin
    case (opcode)
      OPC_LOAD, OPC_OP_IMM,
      OPC_JALR:             immFmt = IMM_I;
      OPC_STORE:            immFmt = IMM_S;
      OPC_BRANCH:           immFmt = IMM_B;
      OPC_LUI, OPC_AUIPC:   immFmt = IMM_U;
      OPC_JAL:              immFmt = IMM_J;
      default:              immFmt = IMM_Z; // OP and AMO
    endcase
  end

endmodule

//--- rvPkg.sv
package rvPkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_AMO    = 7'b0101111 // Only LR.W and SC.W
  } opcodeT;

  // Coarse ALU class from the main decoder
  typedef enum logic [2:0] {
    CLS_MEM    = 3'b000, // Address add
    CLS_BRANCH = 3'b001,
    CLS_OP     = 3'b010,
    CLS_JUMP   = 3'b011, // JAL, JALR, AUIPC
    CLS_AMO    = 3'b100,
    CLS_PASS   = 3'b101, // LUI
    CLS_OP_IMM = 3'b110,
    CLS_NONE   = 3'b111
  } aluClassT;

  // Exact ALU function, 17 entries so five bits
  typedef enum logic [4:0] {
    FN_ADD, FN_SUB, FN_SLL, FN_SLT, FN_SLTU, FN_XOR, FN_SRL, FN_SRA,
    FN_OR, FN_AND,
    FN_EQ, FN_NE, FN_LT, FN_GE, FN_LTU, FN_GEU, // Branch compares
    FN_PASSB
  } aluFnT;

  // Immediate layouts, IMM_Z for instructions without one
  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_Z
  } immFmtT;

endpackage

//--- rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath word width
`define XLEN 32

// Register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address
`define RESET_PC 32'h0000_0000

// func3 codes of the narrow loads
`define LOAD_BYTE   3'b000 // LB
`define LOAD_HALF   3'b001 // LH
`define LOAD_BYTE_U 3'b100 // LBU
`define LOAD_HALF_U 3'b101 // LHU

// LW and LR.W use 3'b010 and return the whole word

`endif
